//--- compile.f
source/issue_pkg.sv
source/priority_pick.sv
source/register_scoreboard.sv
source/dispatch_stage.sv
source/issue_buffer.sv
source/issue_select.sv
source/alu_execute.sv
source/issue_top.sv
verif/issue_tb.sv

//--- source/alu_execute.sv
// Output side: register file read, one-cycle ALU, and the registered writeback.
`default_nettype none

module alu_execute (
	input  wire logic                          CLK,
	input  wire logic                          rst_n,
	input  wire logic                          flush,
	input  wire logic                          iss_valid,
	input  wire issue_pkg::alu_op_t            iss_op,
	input  wire logic [issue_pkg::REG_W-1:0]   iss_rd,
	input  wire logic [issue_pkg::REG_W-1:0]   iss_rs1,
	input  wire logic [issue_pkg::REG_W-1:0]   iss_rs2,
	input  wire logic [issue_pkg::DATA_W-1:0]  iss_imm,
	output logic                               wb_valid,
	output logic      [issue_pkg::REG_W-1:0]   wb_rd,
	output logic      [issue_pkg::DATA_W-1:0]  wb_data
);

	import issue_pkg::*;

	logic [DATA_W-1:0] regfile [REG_CNT];
	logic [DATA_W-1:0] src1;
	logic [DATA_W-1:0] src2;
	logic [DATA_W-1:0] result;
	logic              commit;

	// Two combinational read ports, addressed straight from the issued entry.
	assign src1 = regfile[iss_rs1];
	assign src2 = regfile[iss_rs2];

	always_comb begin
		case (iss_op)
			LI:      result = iss_imm;
			ADD:     result = src1 + src2;
			SUB:     result = src1 - src2;
			AND:     result = src1 & src2;
			OR:      result = src1 | src2;
			XOR:     result = src1 ^ src2;
			default: result = '0;
		endcase
	end

	// A flush in the issue cycle kills the operation before it reaches any state.
	assign commit = iss_valid && !flush;

	// The register file updates at the same edge that raises wb_valid.
	// Flush leaves its contents alone.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int r = 0; r < REG_CNT; r++) begin
				regfile[r] <= '0;
			end
		end else if (commit) begin
			regfile[iss_rd] <= result;
		end
	end

	// wb_valid is a one-cycle pulse per executed micro-op.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= commit;
		end
	end

	// Result and destination ride alongside wb_valid; they mean nothing while it is low.
	always_ff @(posedge CLK) begin
		if (commit) begin
			wb_rd   <= iss_rd;
			wb_data <= result;
		end
	end

endmodule

`default_nettype wire

//--- source/dispatch_stage.sv
// Input side of the issue stage: hazard stalls, scoreboard marking, and the dispatch register.
`default_nettype none

module dispatch_stage (
	input  wire logic                            CLK,
	input  wire logic                            rst_n,
	input  wire logic                            flush,
	input  wire logic                            in_valid,
	input  wire issue_pkg::alu_op_t              in_op,
	input  wire logic [issue_pkg::REG_W-1:0]     in_rd,
	input  wire logic [issue_pkg::REG_W-1:0]     in_rs1,
	input  wire logic [issue_pkg::REG_W-1:0]     in_rs2,
	input  wire logic [issue_pkg::DATA_W-1:0]    in_imm,
	output logic                                 in_ready,
	input  wire logic [issue_pkg::REG_CNT-1:0]   write_pending,
	input  wire logic [issue_pkg::REG_CNT-1:0]   read_pending,
	output logic                                 mark_valid,
	output logic      [issue_pkg::REG_W-1:0]     mark_rd,
	output logic      [issue_pkg::REG_W-1:0]     mark_rs1,
	output logic      [issue_pkg::REG_W-1:0]     mark_rs2,
	output logic                                 mark_uses_src,
	input  wire logic                            buffer_full,
	input  wire logic                            buffer_pop,
	output logic                                 buffer_push,
	output logic      [issue_pkg::ENTRY_W-1:0]   dispat_info
);

	import issue_pkg::*;

	logic         slot_valid_q;
	issue_entry_t slot_q;
	logic         slot_free;
	logic         accept;

	// The held micro-op leaves when a slot is free, or when select frees one this cycle.
	assign buffer_push = slot_valid_q && (!buffer_full || buffer_pop);
	assign dispat_info = slot_q;

	// The dispatch register can take a new micro-op if it is empty or draining now.
	assign slot_free = !slot_valid_q || buffer_push;

	// WAW stall when rd already has a writer in flight.
	// WAR stall when older micro-ops still have to read rd.
	// RAW is not checked here; the entry simply waits in the buffer.
	assign in_ready = slot_free && !write_pending[in_rd] && !read_pending[in_rd];
	assign accept = in_valid && in_ready;

	// Acceptance books the destination and the source reads in the scoreboard.
	assign mark_valid    = accept;
	assign mark_rd       = in_rd;
	assign mark_rs1      = in_rs1;
	assign mark_rs2      = in_rs2;
	assign mark_uses_src = op_uses_src(in_op);

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			slot_valid_q <= 1'b0;
		end else if (accept) begin
			slot_valid_q <= 1'b1;
		end else if (buffer_push) begin
			slot_valid_q <= 1'b0;
		end
	end

	// The payload only loads on acceptance.
	always_ff @(posedge CLK) begin
		if (accept) begin
			slot_q.op  <= in_op;
			slot_q.rd  <= in_rd;
			slot_q.rs1 <= in_rs1;
			slot_q.rs2 <= in_rs2;
			slot_q.imm <= in_imm;
		end
	end

endmodule

`default_nettype wire

//--- source/issue_buffer.sv
// Issue buffer of DP slots of DW bits each; pushes into a free slot and pops by index.
`default_nettype none

module issue_buffer #(
	parameter int DW = 100,
	parameter int DP = 8
) (
	input  wire logic                  CLK,
	input  wire logic                  rst_n,
	input  wire logic                  flush,
	input  wire logic [DW-1:0]         dispat_info,
	input  wire logic                  buffer_push,
	output logic                       buffer_full,
	input  wire logic                  buffer_pop,
	input  wire logic [$clog2(DP)-1:0] pop_index,
	output logic      [DW*DP-1:0]      issue_info_qout,
	output logic      [DP-1:0]         buffer_malloc_qout
);

	logic [DW-1:0]         slot_q [DP];
	logic [DP-1:0]         valid_q;
	logic [DP-1:0]         valid_d;
	logic [$clog2(DP)-1:0] free_index;
	logic                  has_free;
	logic [$clog2(DP)-1:0] push_index;
	logic [DP-1:0]         push_mask;
	logic [DP-1:0]         pop_mask;

	// Search the inverted valid bits for the lowest empty slot.
	priority_pick #(
		.WIDTH(DP)
	) free_pick (
		.req(~valid_q),
		.pos(free_index),
		.any(has_free)
	);

	assign buffer_full = !has_free;

	// On push and pop together the new entry reuses the slot that is leaving.
	// That keeps a push possible while the buffer is full.
	assign push_index = (buffer_push && buffer_pop) ? pop_index : free_index;

	assign push_mask = buffer_push ? (DP'(1) << push_index) : '0;
	assign pop_mask  = buffer_pop ? (DP'(1) << pop_index) : '0;

	// Clear the popped bit first, then set the pushed one, so a shared slot stays valid.
	assign valid_d = (valid_q & ~pop_mask) | push_mask;

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_d;
		end
	end

	// Entry payload only moves on a push.
	always_ff @(posedge CLK) begin
		if (buffer_push) begin
			slot_q[push_index] <= dispat_info;
		end
	end

	// Flatten the slots for the select logic, slot 0 in the lowest bits.
	always_comb begin
		for (int i = 0; i < DP; i++) begin
			issue_info_qout[DW*i +: DW] = slot_q[i];
		end
	end

	assign buffer_malloc_qout = valid_q;

endmodule

`default_nettype wire

//--- source/issue_pkg.sv
// Shared widths, opcodes and the buffer entry layout for the issue stage; import it where needed.
`default_nettype none

package issue_pkg;

	// Register data width in bits.
	localparam int DATA_W = 32;

	// Architectural register count and the index width that addresses it.
	localparam int REG_CNT = 8;
	localparam int REG_W = 3;

	// Issue buffer depth and the slot index width.
	localparam int IB_DEPTH = 8;
	localparam int IB_IDX_W = 3;

	// Each slot reads at most two registers and nine micro-ops can be in flight.
	// Five bits cover that with room to spare.
	localparam int READ_CNT_W = 5;

	// Opcodes of the integer ALU.
	typedef enum logic [2:0] {
		LI  = 3'd0,
		ADD = 3'd1,
		SUB = 3'd2,
		AND = 3'd3,
		OR  = 3'd4,
		XOR = 3'd5
	} alu_op_t;

	// Layout of one buffer entry, from the opcode in the top bits down to the immediate.
	typedef struct packed {
		alu_op_t           op;
		logic [REG_W-1:0]  rd;
		logic [REG_W-1:0]  rs1;
		logic [REG_W-1:0]  rs2;
		logic [DATA_W-1:0] imm;
	} issue_entry_t;

	// Packed entry width, 44 bits.
	localparam int ENTRY_W = $bits(issue_entry_t);

	// Only LI ignores its sources; every other opcode reads both rs1 and rs2.
	function automatic logic op_uses_src(input alu_op_t op);
		return op != LI;
	endfunction

endpackage

`default_nettype wire

//--- source/issue_select.sv
// Wakeup and select: finds ready buffer entries and pops the lowest-index one for execution.
`default_nettype none

module issue_select (
	input  wire logic [issue_pkg::ENTRY_W*issue_pkg::IB_DEPTH-1:0] issue_info_qout,
	input  wire logic [issue_pkg::IB_DEPTH-1:0]                    buffer_malloc_qout,
	input  wire logic [issue_pkg::REG_CNT-1:0]                     write_pending,
	output logic                                                   buffer_pop,
	output logic      [issue_pkg::IB_IDX_W-1:0]                    pop_index,
	output logic                                                   iss_valid,
	output issue_pkg::alu_op_t                                     iss_op,
	output logic      [issue_pkg::REG_W-1:0]                       iss_rd,
	output logic      [issue_pkg::REG_W-1:0]                       iss_rs1,
	output logic      [issue_pkg::REG_W-1:0]                       iss_rs2,
	output logic      [issue_pkg::DATA_W-1:0]                      iss_imm,
	output logic                                                   iss_uses_src
);

	import issue_pkg::*;

	issue_entry_t      entries [IB_DEPTH];
	logic [IB_DEPTH-1:0] ready;
	issue_entry_t      picked;
	logic              any_ready;

	// An entry is ready when it holds a micro-op and none of its used sources
	// still waits for a writer.
	always_comb begin
		for (int i = 0; i < IB_DEPTH; i++) begin
			entries[i] = issue_entry_t'(issue_info_qout[ENTRY_W*i +: ENTRY_W]);
			ready[i] = buffer_malloc_qout[i];
			if (op_uses_src(entries[i].op)) begin
				ready[i] = ready[i] && !write_pending[entries[i].rs1]
					&& !write_pending[entries[i].rs2];
			end
		end
	end

	// Lower slot index wins; this is not program order once slots get reused.
	priority_pick #(
		.WIDTH(IB_DEPTH)
	) ready_pick (
		.req(ready),
		.pos(pop_index),
		.any(any_ready)
	);

	// The pop and the issue happen in the same cycle, nothing is registered here.
	assign buffer_pop = any_ready;
	assign iss_valid  = any_ready;

	assign picked = entries[pop_index];

	assign iss_op       = picked.op;
	assign iss_rd       = picked.rd;
	assign iss_rs1      = picked.rs1;
	assign iss_rs2      = picked.rs2;
	assign iss_imm      = picked.imm;
	assign iss_uses_src = op_uses_src(picked.op);

endmodule

`default_nettype wire

//--- source/issue_top.sv
// Top level of the out-of-order issue stage; instantiate this to drive micro-ops in and watch writebacks.
`default_nettype none

module issue_top (
	input  wire logic                          CLK,
	input  wire logic                          rst_n,
	input  wire logic                          flush,
	input  wire logic                          in_valid,
	input  wire issue_pkg::alu_op_t            in_op,
	input  wire logic [issue_pkg::REG_W-1:0]   in_rd,
	input  wire logic [issue_pkg::REG_W-1:0]   in_rs1,
	input  wire logic [issue_pkg::REG_W-1:0]   in_rs2,
	input  wire logic [issue_pkg::DATA_W-1:0]  in_imm,
	output logic                               in_ready,
	output logic                               wb_valid,
	output logic      [issue_pkg::REG_W-1:0]   wb_rd,
	output logic      [issue_pkg::DATA_W-1:0]  wb_data
);

	import issue_pkg::*;

	// Scoreboard state and the bookings made at dispatch.
	logic [REG_CNT-1:0] write_pending;
	logic [REG_CNT-1:0] read_pending;
	logic               mark_valid;
	logic [REG_W-1:0]   mark_rd;
	logic [REG_W-1:0]   mark_rs1;
	logic [REG_W-1:0]   mark_rs2;
	logic               mark_uses_src;

	// Buffer handshakes.
	logic                        buffer_push;
	logic                        buffer_full;
	logic                        buffer_pop;
	logic [IB_IDX_W-1:0]         pop_index;
	logic [ENTRY_W-1:0]          dispat_info;
	logic [ENTRY_W*IB_DEPTH-1:0] issue_info_qout;
	logic [IB_DEPTH-1:0]         buffer_malloc_qout;

	// The issued micro-op.
	logic              iss_valid;
	alu_op_t           iss_op;
	logic [REG_W-1:0]  iss_rd;
	logic [REG_W-1:0]  iss_rs1;
	logic [REG_W-1:0]  iss_rs2;
	logic [DATA_W-1:0] iss_imm;
	logic              iss_uses_src;

	dispatch_stage dispatch_stage_inst (.*);

	register_scoreboard register_scoreboard_inst (.*);

	issue_buffer #(
		.DW(ENTRY_W),
		.DP(IB_DEPTH)
	) issue_buffer_inst (.*);

	issue_select issue_select_inst (.*);

	alu_execute alu_execute_inst (.*);

endmodule

`default_nettype wire

//--- source/priority_pick.sv
// Lowest-set-bit priority encoder, instantiated for free-slot search and for ready-entry select.
`default_nettype none

module priority_pick #(
	parameter int WIDTH = 8,
	localparam int POS_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
	input  wire logic [WIDTH-1:0] req,
	output logic [POS_W-1:0]      pos,
	output logic                  any
);

	// Any set bit means the encoded position is meaningful.
	assign any = |req;

	// Scan from the top down so the lowest set bit is the last one to write pos.
	// With no bit set the position stays at zero.
	always_comb begin
		pos = '0;
		for (int i = WIDTH - 1; i >= 0; i--) begin
			if (req[i]) begin
				pos = POS_W'(i);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/register_scoreboard.sv
// Per-register pending-write bits and pending-read counters, consulted by dispatch and select.
`default_nettype none

module register_scoreboard (
	input  wire logic                             CLK,
	input  wire logic                             rst_n,
	input  wire logic                             flush,
	input  wire logic                             mark_valid,
	input  wire logic [issue_pkg::REG_W-1:0]      mark_rd,
	input  wire logic [issue_pkg::REG_W-1:0]      mark_rs1,
	input  wire logic [issue_pkg::REG_W-1:0]      mark_rs2,
	input  wire logic                             mark_uses_src,
	input  wire logic                             iss_valid,
	input  wire logic [issue_pkg::REG_W-1:0]      iss_rs1,
	input  wire logic [issue_pkg::REG_W-1:0]      iss_rs2,
	input  wire logic                             iss_uses_src,
	input  wire logic                             wb_valid,
	input  wire logic [issue_pkg::REG_W-1:0]      wb_rd,
	output logic      [issue_pkg::REG_CNT-1:0]    write_pending,
	output logic      [issue_pkg::REG_CNT-1:0]    read_pending
);

	import issue_pkg::*;

	logic [REG_CNT-1:0]    wr_pend_q;
	logic [REG_CNT-1:0]    wr_set;
	logic [REG_CNT-1:0]    wr_clr;
	logic [READ_CNT_W-1:0] rd_cnt_q [REG_CNT];
	logic [READ_CNT_W-1:0] rd_cnt_d [REG_CNT];

	// The register file is written at the edge where wb_valid rises, so the pending
	// view drops the written register right away and a consumer can issue this cycle.
	assign write_pending = wr_pend_q & ~wr_clr;

	always_comb begin
		for (int r = 0; r < REG_CNT; r++) begin
			wr_set[r] = mark_valid && (mark_rd == REG_W'(r));
			wr_clr[r] = wb_valid && (wb_rd == REG_W'(r));
			// Mark and issue can touch the same counter in one cycle, and rs1 may equal
			// rs2, so both sides contribute up to two and the sum is applied at once.
			rd_cnt_d[r] = rd_cnt_q[r];
			if (mark_valid && mark_uses_src) begin
				rd_cnt_d[r] = rd_cnt_d[r] + READ_CNT_W'(mark_rs1 == REG_W'(r))
					+ READ_CNT_W'(mark_rs2 == REG_W'(r));
			end
			if (iss_valid && iss_uses_src) begin
				rd_cnt_d[r] = rd_cnt_d[r] - READ_CNT_W'(iss_rs1 == REG_W'(r))
					- READ_CNT_W'(iss_rs2 == REG_W'(r));
			end
			read_pending[r] = |rd_cnt_q[r];
		end
	end

	// A new writer accepted while the old result lands keeps its bit, so set wins over clear.
	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			wr_pend_q <= '0;
			for (int r = 0; r < REG_CNT; r++) begin
				rd_cnt_q[r] <= '0;
			end
		end else begin
			wr_pend_q <= (wr_pend_q & ~wr_clr) | wr_set;
			rd_cnt_q  <= rd_cnt_d;
		end
	end

endmodule

`default_nettype wire

//--- verif/issue_tb.sv
// Table-driven testbench for issue_top; compile it with the RTL and run issue_tb as the top module.
`default_nettype none

module issue_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import issue_pkg::*;

	// One table row: the micro-op, a flush request ahead of it, and the in-order result.
	typedef struct packed {
		alu_op_t           op;
		logic [REG_W-1:0]  rd;
		logic [REG_W-1:0]  rs1;
		logic [REG_W-1:0]  rs2;
		logic [DATA_W-1:0] imm;
		bit                flush_before;
		logic [DATA_W-1:0] expected;
	} row_t;

	// A result that has been accepted but not yet written back.
	typedef struct packed {
		logic [REG_W-1:0]  rd;
		logic [DATA_W-1:0] value;
		int                row;
	} pending_t;

	logic              CLK;
	logic              rst_n;
	logic              flush;
	logic              in_valid;
	alu_op_t           in_op;
	logic [REG_W-1:0]  in_rd;
	logic [REG_W-1:0]  in_rs1;
	logic [REG_W-1:0]  in_rs2;
	logic [DATA_W-1:0] in_imm;
	logic              in_ready;
	logic              wb_valid;
	logic [REG_W-1:0]  wb_rd;
	logic [DATA_W-1:0] wb_data;

	row_t        tbl[$];
	pending_t    outstanding[$];
	logic [31:0] lfsr_state = 32'h95d01d4a;
	bit          table_built = 1'b0;
	int          error_count = 0;
	int          wb_count = 0;
	int          flushed_count = 0;
	int          bp_stalls = 0;
	int          bp_first;
	int          bp_last;

	issue_top issue_top_inst (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.in_valid(in_valid),
		.in_op(in_op),
		.in_rd(in_rd),
		.in_rs1(in_rs1),
		.in_rs2(in_rs2),
		.in_imm(in_imm),
		.in_ready(in_ready),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	// 8 ns clock period.
	always #4 CLK = ~CLK;

	// Fibonacci LFSR over x^32 + x^22 + x^2 + x + 1, one step per bit.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] w;
		w = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
		return w;
	endfunction

	// In-order meaning of each opcode; LI takes the immediate and ignores both sources.
	function automatic logic [DATA_W-1:0] model_result(input alu_op_t op,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
			input logic [DATA_W-1:0] imm);
		case (op)
			LI:      return imm;
			ADD:     return a + b;
			SUB:     return a - b;
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			default: return '0;
		endcase
	endfunction

	function automatic void add_row(input alu_op_t op, input int rd, input int rs1,
			input int rs2, input bit flush_before);
		row_t r;
		r.op = op;
		r.rd = REG_W'(rd);
		r.rs1 = REG_W'(rs1);
		r.rs2 = REG_W'(rs2);
		r.imm = rand_word();
		r.flush_before = flush_before;
		r.expected = '0;
		tbl.push_back(r);
	endfunction

	// No row names its destination as a source, since such an entry would wait on itself.
	function automatic void build_table();
		// Independent LIs to every register.
		for (int r = 0; r < REG_CNT; r++) begin
			add_row(LI, r, 0, 0, 1'b0);
		end
		// Dependent chains, with rs1 equal to rs2 and reused destinations.
		add_row(ADD, 1, 0, 2, 1'b0);
		add_row(SUB, 3, 1, 1, 1'b0);
		add_row(AND, 1, 3, 0, 1'b0);
		add_row(OR, 4, 1, 3, 1'b0);
		add_row(XOR, 2, 4, 1, 1'b0);
		add_row(XOR, 5, 6, 6, 1'b0);
		add_row(ADD, 6, 2, 2, 1'b0);
		add_row(SUB, 7, 6, 4, 1'b0);
		// A long chain with independent LIs between its links, so the LIs issue first.
		add_row(ADD, 3, 2, 1, 1'b0);
		add_row(LI, 0, 0, 0, 1'b0);
		add_row(SUB, 4, 3, 2, 1'b0);
		add_row(LI, 7, 0, 0, 1'b0);
		add_row(XOR, 5, 4, 3, 1'b0);
		add_row(LI, 6, 0, 0, 1'b0);
		add_row(OR, 2, 5, 4, 1'b0);
		add_row(LI, 0, 0, 0, 1'b0);
		add_row(AND, 1, 2, 5, 1'b0);
		add_row(LI, 7, 0, 0, 1'b0);
		// Burst behind the slow r4 chain; the second write to r5 must stall at the input.
		bp_first = tbl.size();
		add_row(ADD, 2, 1, 1, 1'b0);
		add_row(ADD, 3, 2, 2, 1'b0);
		add_row(ADD, 4, 3, 3, 1'b0);
		add_row(ADD, 5, 4, 0, 1'b0);
		add_row(XOR, 6, 4, 4, 1'b0);
		add_row(SUB, 7, 4, 0, 1'b0);
		add_row(OR, 5, 6, 4, 1'b0);
		add_row(AND, 6, 4, 5, 1'b0);
		add_row(ADD, 7, 6, 5, 1'b0);
		add_row(XOR, 2, 7, 4, 1'b0);
		bp_last = tbl.size() - 1;
		// Flush while the burst is still in flight; later rows load every source first.
		add_row(LI, 1, 0, 0, 1'b1);
		add_row(LI, 2, 0, 0, 1'b0);
		add_row(ADD, 3, 1, 2, 1'b0);
		add_row(LI, 4, 0, 0, 1'b0);
		add_row(SUB, 5, 3, 4, 1'b0);
		add_row(XOR, 6, 5, 5, 1'b0);
		add_row(AND, 7, 3, 1, 1'b0);
		add_row(OR, 0, 6, 7, 1'b0);
	endfunction

	// Sequential reference model: run the rows in table order over a zeroed register file.
	function automatic void fill_expected();
		logic [DATA_W-1:0] regs [REG_CNT];
		for (int r = 0; r < REG_CNT; r++) begin
			regs[r] = '0;
		end
		for (int i = 0; i < tbl.size(); i++) begin
			tbl[i].expected = model_result(tbl[i].op, regs[tbl[i].rs1], regs[tbl[i].rs2],
				tbl[i].imm);
			regs[tbl[i].rd] = tbl[i].expected;
		end
	endfunction

	// Offer one row and hold it until in_ready is high, looking 1 ns after the falling edge.
	task automatic apply_row(input int idx);
		pending_t p;
		@(negedge CLK);
		in_valid = 1'b1;
		in_op = tbl[idx].op;
		in_rd = tbl[idx].rd;
		in_rs1 = tbl[idx].rs1;
		in_rs2 = tbl[idx].rs2;
		in_imm = tbl[idx].imm;
		#1;
		while (in_ready !== 1'b1) begin
			if (idx >= bp_first && idx <= bp_last) begin
				bp_stalls++;
			end
			@(negedge CLK);
			#1;
		end
		// Nothing changes before the next rising edge, so the row is taken there.
		p.rd = tbl[idx].rd;
		p.value = tbl[idx].expected;
		p.row = idx;
		outstanding.push_back(p);
		@(posedge CLK);
	endtask

	// Pulse flush for one edge, then check the quiet cycle that follows it.
	task automatic apply_flush();
		@(negedge CLK);
		in_valid = 1'b0;
		flush = 1'b1;
		@(posedge CLK);
		flushed_count += outstanding.size();
		outstanding.delete();
		@(negedge CLK);
		flush = 1'b0;
		assert (wb_valid === 1'b0) else begin
			error_count++;
			$display("mismatch at %0t: wb_valid after flush expected 0 got %b", $time, wb_valid);
		end
		assert (in_ready === 1'b1) else begin
			error_count++;
			$display("mismatch at %0t: in_ready after flush expected 1 got %b", $time, in_ready);
		end
	endtask

	// Match a writeback to the oldest outstanding result for the same register.
	task automatic check_writeback();
		int hit;
		hit = -1;
		wb_count++;
		for (int k = 0; k < outstanding.size(); k++) begin
			if (hit < 0 && outstanding[k].rd == wb_rd) begin
				hit = k;
			end
		end
		assert (hit >= 0) else begin
			error_count++;
			$display("At %0t a writeback arrived for x%0d, which has no outstanding result",
				$time, wb_rd);
		end
		if (hit >= 0) begin
			assert (wb_data === outstanding[hit].value) else begin
				error_count++;
				$display("mismatch at %0t: wb_data for x%0d (row %0d) expected %h got %h",
					$time, wb_rd, outstanding[hit].row, outstanding[hit].value, wb_data);
			end
			outstanding.delete(hit);
		end
	endtask

	task automatic finish_run();
		$display("Run complete: %0d errors, %0d writebacks, %0d results flushed",
			error_count, wb_count, flushed_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	// Registered outputs are sampled at the falling edge, halfway between updates.
	always @(negedge CLK) begin
		if (rst_n === 1'b1 && wb_valid === 1'b1) begin
			check_writeback();
		end
	end

	// Forty cycles per row is far more than the slowest row needs.
	initial begin
		wait (table_built);
		repeat (tbl.size() * 40) @(posedge CLK);
		error_count++;
		$display("The run did not finish within %0d cycles and was stopped", tbl.size() * 40);
		finish_run();
	end

	initial begin
		CLK = 1'b0;
		rst_n = 1'b0;
		flush = 1'b0;
		in_valid = 1'b0;
		in_op = LI;
		in_rd = '0;
		in_rs1 = '0;
		in_rs2 = '0;
		in_imm = '0;
		build_table();
		fill_expected();
		table_built = 1'b1;
		// Sixteen rising edges with reset held low, each checked at the falling edge after it.
		repeat (16) begin
			@(posedge CLK);
			@(negedge CLK);
			assert (wb_valid === 1'b0) else begin
				error_count++;
				$display("mismatch at %0t: wb_valid in reset expected 0 got %b", $time, wb_valid);
			end
		end
		rst_n = 1'b1;
		@(negedge CLK);
		assert (wb_valid === 1'b0 && in_ready === 1'b1) else begin
			error_count++;
			$display("mismatch at %0t: wb_valid/in_ready after reset expected 0/1 got %b/%b",
				$time, wb_valid, in_ready);
		end
		for (int i = 0; i < tbl.size(); i++) begin
			if (tbl[i].flush_before) begin
				apply_flush();
			end
			apply_row(i);
		end
		@(negedge CLK);
		in_valid = 1'b0;
		while (outstanding.size() != 0) begin
			@(negedge CLK);
		end
		// A few idle cycles catch any stray writeback.
		repeat (10) @(negedge CLK);
		assert (bp_stalls > 0) else begin
			error_count++;
			$display("in_ready never went low during the back-pressure burst");
		end
		assert (wb_count + flushed_count == tbl.size()) else begin
			error_count++;
			$display("%0d writebacks and %0d flushed results do not account for %0d rows",
				wb_count, flushed_count, tbl.size());
		end
		finish_run();
	end

endmodule

`default_nettype wire
